/* robPkg.sv */
package robPkg;

  // core sizes
  localparam int numArchRegs   = 8;
  localparam int numPhysRegs   = 32;
  localparam int numRobEntries = 8;
  localparam int numLanes      = 4;

  typedef logic [$clog2(numArchRegs)-1:0]   archIdx_t;
  typedef logic [$clog2(numPhysRegs)-1:0]   physIdx_t;
  typedef logic [$clog2(numRobEntries)-1:0] robIdx_t;

  typedef enum logic [1:0] {
    opAdd = 2'd0,
    opMul = 2'd1,
    opDiv = 2'd2
  } opcode_t;

  typedef enum logic [1:0] {
    laneIdle = 2'd0,
    laneBusy = 2'd1,
    laneDone = 2'd2
  } laneState_t;

  typedef struct packed {
    archIdx_t destArch;
    opcode_t  opcode;
    logic     halt;
  } dispatchPacket_t;

  typedef struct packed {
    opcode_t opcode;
    robIdx_t robIdx;
  } issuePacket_t;

  typedef struct packed {
    logic    valid;
    robIdx_t robIdx;
  } completePacket_t;

  typedef struct packed {
    logic     valid;
    archIdx_t destArch;
    physIdx_t physReg;
    physIdx_t oldPhysReg;
    logic     halt;
  } retirePacket_t;

  // execution latency in cycles per opcode
  function automatic logic [2:0] opLatency(opcode_t op);
    case (op)
      opAdd:   return 3'd1;
      opMul:   return 3'd3;
      opDiv:   return 3'd6;
      default: return 3'd1;
    endcase
  endfunction

endpackage

/* freeList.sv */
`timescale 1ns/1ns

module freeList (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatchFire,
  input  robPkg::retirePacket_t retire,
  output robPkg::physIdx_t      freeReg,
  output logic                  freeAvail
);

  robPkg::physIdx_t regs [robPkg::numPhysRegs];
  robPkg::physIdx_t head;
  robPkg::physIdx_t tail;
  logic [$clog2(robPkg::numPhysRegs):0] count;

  logic push;
  logic pop;

  assign push = retire.valid;
  assign pop  = dispatchFire;

  assign freeReg   = regs[head];
  assign freeAvail = (count != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // registers above the architectural range start out free
      for (int i = 0; i < robPkg::numPhysRegs; i++) begin
        regs[i] <= robPkg::physIdx_t'(i + robPkg::numArchRegs);
      end
      head  <= '0;
      tail  <= robPkg::physIdx_t'(robPkg::numPhysRegs - robPkg::numArchRegs);
      count <= ($clog2(robPkg::numPhysRegs)+1)'(robPkg::numPhysRegs - robPkg::numArchRegs);
    end else begin
      if (push) begin
        regs[tail] <= retire.oldPhysReg;
        tail       <= tail + 1'b1;
      end
      if (pop) begin
        head <= head + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // dispatch must have seen freeAvail before popping
  popNotEmpty: assert property (@(posedge clock) disable iff (reset)
    dispatchFire |-> freeAvail);

endmodule

/* mapTable.sv */
`timescale 1ns/1ns

module mapTable (
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatchFire,
  input  robPkg::archIdx_t destArch,
  input  robPkg::physIdx_t newPhys,
  output robPkg::physIdx_t oldPhys
);

  robPkg::physIdx_t map [robPkg::numArchRegs];

  // previous mapping goes to the ROB as the register to free later
  assign oldPhys = map[destArch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map
      for (int i = 0; i < robPkg::numArchRegs; i++) begin
        map[i] <= robPkg::physIdx_t'(i);
      end
    end else if (dispatchFire) begin
      map[destArch] <= newPhys;
    end
  end

endmodule

/* dispatchStage.sv */
`timescale 1ns/1ns

module dispatchStage (
  input  logic                            dispatchValid,
  input  robPkg::dispatchPacket_t         dispatch,
  input  logic                            robHasRoom,
  input  logic                            freeAvail,
  input  logic [robPkg::numLanes-1:0]     laneIdle,
  input  robPkg::robIdx_t                 robTail,
  output logic                            dispatchReady,
  output logic                            dispatchFire,
  output logic [robPkg::numLanes-1:0]     laneStart,
  output robPkg::issuePacket_t            issue
);

  logic [robPkg::numLanes-1:0] pick;

  // all three resources needed before accepting
  assign dispatchReady = robHasRoom & freeAvail & (|laneIdle);
  assign dispatchFire  = dispatchValid & dispatchReady;

  // lowest idle lane wins, so scan downward
  always_comb begin
    pick = '0;
    for (int i = robPkg::numLanes - 1; i >= 0; i--) begin
      if (laneIdle[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  assign laneStart = dispatchFire ? pick : '0;

  assign issue.opcode = dispatch.opcode;
  assign issue.robIdx = robTail;

endmodule

/* execLane.sv */
`timescale 1ns/1ns

module execLane (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    laneStart,
  input  robPkg::issuePacket_t    issue,
  input  logic                    laneGrant,
  output logic                    laneIdle,
  output robPkg::completePacket_t laneComplete
);

  robPkg::laneState_t state;
  logic [2:0]         count;
  robPkg::robIdx_t    robIdx;

  assign laneIdle            = (state == robPkg::laneIdle);
  assign laneComplete.valid  = (state == robPkg::laneDone);
  assign laneComplete.robIdx = robIdx;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= robPkg::laneIdle;
      count <= '0;
    end else begin
      case (state)
        robPkg::laneIdle: begin
          if (laneStart) begin
            state <= robPkg::laneBusy;
            count <= robPkg::opLatency(issue.opcode);
          end
        end
        robPkg::laneBusy: begin
          // last cycle of the latency
          if (count == 3'd1) begin
            state <= robPkg::laneDone;
          end
          count <= count - 1'b1;
        end
        robPkg::laneDone: begin
          if (laneGrant) begin
            state <= robPkg::laneIdle;
          end
        end
        default: state <= robPkg::laneIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (laneStart) begin
      robIdx <= issue.robIdx;
    end
  end

  // dispatch only starts lanes that report idle
  startWhenIdle: assert property (@(posedge clock) disable iff (reset)
    laneStart |-> state == robPkg::laneIdle);

endmodule

/* completeArbiter.sv */
`timescale 1ns/1ns

module completeArbiter (
  input  robPkg::completePacket_t     laneComplete [robPkg::numLanes],
  output logic [robPkg::numLanes-1:0] laneGrant,
  output robPkg::completePacket_t     robComplete
);

  // fixed priority, lane 0 highest
  always_comb begin
    laneGrant   = '0;
    robComplete = '0;
    for (int i = robPkg::numLanes - 1; i >= 0; i--) begin
      if (laneComplete[i].valid) begin
        laneGrant    = '0;
        laneGrant[i] = 1'b1;
        robComplete  = laneComplete[i];
      end
    end
  end

endmodule

/* reorderBuffer.sv */
`timescale 1ns/1ns

module reorderBuffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatchFire,
  input  robPkg::archIdx_t        destArch,
  input  robPkg::physIdx_t        newPhys,
  input  robPkg::physIdx_t        oldPhys,
  input  logic                    halt,
  input  robPkg::completePacket_t robComplete,
  output robPkg::robIdx_t         robTail,
  output logic                    robHasRoom,
  output robPkg::retirePacket_t   retire
);

  typedef struct packed {
    robPkg::archIdx_t destArch;
    robPkg::physIdx_t physReg;
    robPkg::physIdx_t oldPhysReg;
    logic             halt;
  } robPayload_t;

  logic [robPkg::numRobEntries-1:0] entryValid;
  logic [robPkg::numRobEntries-1:0] entryComplete;
  robPayload_t                      payload [robPkg::numRobEntries];

  robPkg::robIdx_t head;
  robPkg::robIdx_t tail;
  logic            retireNow;
  robPayload_t     headEntry;

  assign headEntry = payload[head];
  assign retireNow = entryValid[head] & entryComplete[head];

  // tail slot is usable if empty or leaving this cycle
  assign robHasRoom = !entryValid[tail] || retireNow;
  assign robTail    = tail;

  assign retire.valid      = retireNow;
  assign retire.destArch   = headEntry.destArch;
  assign retire.physReg    = headEntry.physReg;
  assign retire.oldPhysReg = headEntry.oldPhysReg;
  assign retire.halt       = retireNow & headEntry.halt;

  always_ff @(posedge clock) begin
    if (reset) begin
      head          <= '0;
      tail          <= '0;
      entryValid    <= '0;
      entryComplete <= '0;
    end else begin
      if (retireNow) begin
        entryValid[head]    <= 1'b0;
        entryComplete[head] <= 1'b0;
        head                <= head + 1'b1;
      end
      if (robComplete.valid) begin
        entryComplete[robComplete.robIdx] <= 1'b1;
      end
      // a full buffer refills the slot that retires, so dispatch goes last
      if (dispatchFire) begin
        entryValid[tail]    <= 1'b1;
        entryComplete[tail] <= 1'b0;
        tail                <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dispatchFire) begin
      payload[tail].destArch   <= destArch;
      payload[tail].physReg    <= newPhys;
      payload[tail].oldPhysReg <= oldPhys;
      payload[tail].halt       <= halt;
    end
  end

  // a lane only finishes work that was dispatched into a live entry
  completeOnValid: assert property (@(posedge clock) disable iff (reset)
    robComplete.valid |-> entryValid[robComplete.robIdx]);

endmodule

/* renameCore.sv */
`timescale 1ns/1ns

module renameCore (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatchValid,
  input  robPkg::dispatchPacket_t dispatch,
  output logic                    dispatchReady,
  output robPkg::retirePacket_t   retire
);

  logic                        dispatchFire;
  logic                        freeAvail;
  logic                        robHasRoom;
  robPkg::physIdx_t            freeReg;
  robPkg::physIdx_t            oldPhys;
  robPkg::robIdx_t             robTail;
  robPkg::issuePacket_t        issue;
  robPkg::completePacket_t     robComplete;
  logic [robPkg::numLanes-1:0] laneIdle;
  logic [robPkg::numLanes-1:0] laneStart;
  logic [robPkg::numLanes-1:0] laneGrant;
  robPkg::completePacket_t     laneComplete [robPkg::numLanes];

  freeList freeListInst (
    .clock        (clock),
    .reset        (reset),
    .dispatchFire (dispatchFire),
    .retire       (retire),
    .freeReg      (freeReg),
    .freeAvail    (freeAvail)
  );

  mapTable mapTableInst (
    .clock        (clock),
    .reset        (reset),
    .dispatchFire (dispatchFire),
    .destArch     (dispatch.destArch),
    .newPhys      (freeReg),
    .oldPhys      (oldPhys)
  );

  dispatchStage dispatchStageInst (
    .dispatchValid (dispatchValid),
    .dispatch      (dispatch),
    .robHasRoom    (robHasRoom),
    .freeAvail     (freeAvail),
    .laneIdle      (laneIdle),
    .robTail       (robTail),
    .dispatchReady (dispatchReady),
    .dispatchFire  (dispatchFire),
    .laneStart     (laneStart),
    .issue         (issue)
  );

  for (genvar i = 0; i < robPkg::numLanes; i++) begin : gLane
    execLane laneInst (
      .clock        (clock),
      .reset        (reset),
      .laneStart    (laneStart[i]),
      .issue        (issue),
      .laneGrant    (laneGrant[i]),
      .laneIdle     (laneIdle[i]),
      .laneComplete (laneComplete[i])
    );
  end

  completeArbiter completeArbiterInst (
    .laneComplete (laneComplete),
    .laneGrant    (laneGrant),
    .robComplete  (robComplete)
  );

  reorderBuffer reorderBufferInst (
    .clock        (clock),
    .reset        (reset),
    .dispatchFire (dispatchFire),
    .destArch     (dispatch.destArch),
    .newPhys      (freeReg),
    .oldPhys      (oldPhys),
    .halt         (dispatch.halt),
    .robComplete  (robComplete),
    .robTail      (robTail),
    .robHasRoom   (robHasRoom),
    .retire       (retire)
  );

endmodule

/* tb_renameCore.sv */
`timescale 1ns/1ns

module tb_renameCore;

  typedef struct packed {
    robPkg::archIdx_t destArch;
    robPkg::physIdx_t physReg;
    robPkg::physIdx_t oldPhysReg;
    logic             halt;
  } expEntry_t;

  // 52 instructions over all tests, 200 cycles each
  localparam int numInstr       = 52;
  localparam int watchdogCycles = numInstr * 200 + 100;

  logic                    clock;
  logic                    reset;
  logic                    dispatchValid;
  robPkg::dispatchPacket_t dispatch;
  logic                    dispatchReady;
  robPkg::retirePacket_t   retire;

  // reference model
  expEntry_t        orderQ [$];
  robPkg::physIdx_t freeQ [$];
  robPkg::physIdx_t modelMap [robPkg::numArchRegs];

  robPkg::retirePacket_t lastRetire;
  int checkCount;
  int errCount;
  int retireCount;
  int haltCount;
  int lastStalls;

  renameCore DUT (
    .clock         (clock),
    .reset         (reset),
    .dispatchValid (dispatchValid),
    .dispatch      (dispatch),
    .dispatchReady (dispatchReady),
    .retire        (retire)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got != exp) begin
      errCount++;
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finishRun(input bit timedOut);
    $display("checks %0d errors %0d timeout %0d", checkCount, errCount, timedOut);
    if (errCount == 0 && !timedOut) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // model state right after reset
  task automatic resetModel();
    orderQ.delete();
    freeQ.delete();
    for (int i = robPkg::numArchRegs; i < robPkg::numPhysRegs; i++) begin
      freeQ.push_back(robPkg::physIdx_t'(i));
    end
    for (int i = 0; i < robPkg::numArchRegs; i++) begin
      modelMap[i] = robPkg::physIdx_t'(i);
    end
  endtask

  // rename rule: pop the oldest free register, remember the previous mapping
  task automatic modelDispatch(input robPkg::archIdx_t dest, input logic halt);
    expEntry_t exp;
    exp.destArch   = dest;
    exp.physReg    = freeQ.pop_front();
    exp.oldPhysReg = modelMap[dest];
    exp.halt       = halt;
    modelMap[dest] = exp.physReg;
    orderQ.push_back(exp);
  endtask

  // packet held until ready, transfer happens at the next rising edge
  task automatic dispatchOne(input robPkg::archIdx_t dest, input robPkg::opcode_t op,
                             input logic halt);
    @(negedge clock);
    dispatchValid     = 1'b1;
    dispatch.destArch = dest;
    dispatch.opcode   = op;
    dispatch.halt     = halt;
    lastStalls        = 0;
    while (!dispatchReady) begin
      lastStalls++;
      @(negedge clock);
    end
    modelDispatch(dest, halt);
  endtask

  task automatic releaseDispatch();
    @(negedge clock);
    dispatchValid = 1'b0;
    dispatch      = '0;
  endtask

  task automatic waitDrain(input int limit);
    int n;
    n = 0;
    while (orderQ.size() != 0 && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (orderQ.size() != 0) begin
      errCount++;
      $display("retirement stalled with %0d instructions still in flight", orderQ.size());
    end
  endtask

  // retire monitor
  always @(negedge clock) begin
    expEntry_t exp;
    if (!reset && retire.valid) begin
      if (orderQ.size() == 0) begin
        errCount++;
        $display("retirement seen with no instruction in flight at %0t", $time);
      end else begin
        exp = orderQ.pop_front();
        checkValue("retire.destArch", 32'(retire.destArch), 32'(exp.destArch));
        checkValue("retire.physReg", 32'(retire.physReg), 32'(exp.physReg));
        checkValue("retire.oldPhysReg", 32'(retire.oldPhysReg), 32'(exp.oldPhysReg));
        checkValue("retire.halt", 32'(retire.halt), 32'(exp.halt));
        // freed register goes to the back of the model free list
        freeQ.push_back(exp.oldPhysReg);
      end
      lastRetire = retire;
      retireCount++;
      if (retire.halt) begin
        haltCount++;
      end
    end
  end

  task automatic testReset();
    reset = 1'b1;
    repeat (4) begin
      @(negedge clock);
      checkValue("retire.valid", 32'(retire.valid), 32'd0);
      checkValue("dispatchReady", 32'(dispatchReady), 32'd1);
    end
    reset = 1'b0;
    resetModel();
    @(negedge clock);
    checkValue("retire.valid", 32'(retire.valid), 32'd0);
    checkValue("dispatchReady", 32'(dispatchReady), 32'd1);
  endtask

  task automatic testSingleAdd();
    dispatchOne(3'd3, robPkg::opAdd, 1'b0);
    releaseDispatch();
    waitDrain(200);
    // first free register after reset is 8, r3 was mapped to itself
    checkValue("retire.physReg", 32'(lastRetire.physReg), 32'd8);
    checkValue("retire.oldPhysReg", 32'(lastRetire.oldPhysReg), 32'd3);
    checkValue("retire.halt", 32'(lastRetire.halt), 32'd0);
  endtask

  task automatic testProgramOrder();
    // add finishes first but has to wait for the div
    dispatchOne(3'd1, robPkg::opDiv, 1'b0);
    dispatchOne(3'd2, robPkg::opAdd, 1'b0);
    dispatchOne(3'd4, robPkg::opMul, 1'b0);
    releaseDispatch();
    waitDrain(600);
  endtask

  task automatic testBackPressure();
    int startCount;
    startCount = retireCount;
    for (int i = 0; i < 5; i++) begin
      dispatchOne(robPkg::archIdx_t'(i), robPkg::opDiv, 1'b0);
    end
    if (lastStalls == 0) begin
      errCount++;
      $display("dispatchReady stayed high with all four lanes busy");
    end
    releaseDispatch();
    waitDrain(1000);
    checkValue("retireCount", 32'(retireCount - startCount), 32'd5);
  endtask

  task automatic testRecycle();
    robPkg::archIdx_t dest;
    robPkg::opcode_t  op;
    for (int i = 0; i < 40; i++) begin
      dest = robPkg::archIdx_t'($urandom % 8);
      op   = robPkg::opcode_t'(2'($urandom % 3));
      dispatchOne(dest, op, 1'b0);
    end
    releaseDispatch();
    waitDrain(8000);
  endtask

  task automatic testHalt();
    int startHalts;
    startHalts = haltCount;
    dispatchOne(3'd5, robPkg::opAdd, 1'b0);
    dispatchOne(3'd6, robPkg::opMul, 1'b1);
    dispatchOne(3'd7, robPkg::opAdd, 1'b0);
    releaseDispatch();
    waitDrain(600);
    checkValue("haltCount", 32'(haltCount - startHalts), 32'd1);
  endtask

  initial begin
    void'($urandom(93));
    reset         = 1'b1;
    dispatchValid = 1'b0;
    dispatch      = '0;
    lastRetire    = '0;
    checkCount    = 0;
    errCount      = 0;
    retireCount   = 0;
    haltCount     = 0;
    lastStalls    = 0;
    resetModel();
    testReset();
    testSingleAdd();
    testProgramOrder();
    testBackPressure();
    testRecycle();
    testHalt();
    repeat (4) @(negedge clock);
    finishRun(1'b0);
  end

  // watchdog
  initial begin
    repeat (watchdogCycles) @(posedge clock);
    $display("watchdog expired after %0d cycles, a test hung", watchdogCycles);
    finishRun(1'b1);
  end

endmodule

/* tb.f */
robPkg.sv
freeList.sv
mapTable.sv
dispatchStage.sv
execLane.sv
completeArbiter.sv
reorderBuffer.sv
renameCore.sv
tb_renameCore.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module tb_renameCore -f tb.f -o simRenameCore \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simRenameCore > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
